// File: bench/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter dcache_pkg::word_t FILL_KEY = 32'h0,
    parameter int                SEED     = 1
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid_i,
    input  logic               req_we_i,
    input  dcache_pkg::addr_t  req_addr_i,
    input  dcache_pkg::line_t  req_wdata_i,
    output logic               req_ready_o,
    output logic               resp_valid_o,
    output dcache_pkg::line_t  resp_rdata_o
);
    import dcache_pkg::*;

    line_t      mem [addr_t];
    int         seed = SEED;
    logic       ready_q = 1'b0;
    logic       busy_q = 1'b0;
    logic       resp_q = 1'b0;
    line_t      rdata_q = '0;
    logic [1:0] delay_q = '0;

    function automatic line_t stored_line(addr_t a);
        line_t l;
        if (mem.exists(a)) begin
            return mem[a];
        end
        // unwritten words carry their own address
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w*WORD_W +: WORD_W] = (a + w * 4) ^ FILL_KEY;
        end
        return l;
    endfunction

    always @(posedge clk) begin
        word_t r;
        r = $random(seed);
        if (rst) begin
            ready_q <= 1'b0;
            busy_q  <= 1'b0;
            resp_q  <= 1'b0;
        end else begin
            // ready drops on about one cycle in four
            ready_q <= (r[1:0] != 2'b00);
            resp_q  <= 1'b0;
            if (req_valid_i && ready_q) begin
                if (req_we_i) begin
                    mem[req_addr_i] = req_wdata_i;
                end else begin
                    rdata_q <= stored_line(req_addr_i);
                end
                busy_q  <= 1'b1;
                delay_q <= r[3:2];
            end else if (busy_q) begin
                if (delay_q == 2'd0) begin
                    resp_q <= 1'b1;
                    busy_q <= 1'b0;
                end else begin
                    delay_q <= delay_q - 2'd1;
                end
            end
        end
    end

    assign req_ready_o  = ready_q;
    assign resp_valid_o = resp_q;
    assign resp_rdata_o = rdata_q;

endmodule

// File: bench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    // about 400 accesses of a few memory round trips each with a tenfold margin
    localparam int MAX_CYCLES = 20000;
    localparam word_t FILL_KEY = 32'h5a3c_96e1;

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    logic  req_valid_i = 1'b0;
    addr_t req_addr_i = '0;
    strb_t req_wstrb_i = '0;
    word_t req_wdata_i = '0;
    logic  req_ready_o;
    logic  resp_valid_o;
    word_t resp_rdata_o;
    logic  mem_req_valid_o;
    logic  mem_req_we_o;
    addr_t mem_req_addr_o;
    line_t mem_req_wdata_o;
    logic  mem_req_ready_i;
    logic  mem_resp_valid_i;
    line_t mem_resp_rdata_i;

    logic [7:0] golden [addr_t];
    strb_t merge_strb [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
    int    seed = 59024;
    int    err_cnt = 0;
    int    tests_run = 0;
    int    tests_passed = 0;
    int    cycles = 0;
    logic  pending = 1'b0;
    logic  fill_seen = 1'b0;
    logic  exp_load = 1'b0;
    word_t exp_rdata = '0;
    addr_t cur_addr = '0;
    logic  expect_hit = 1'b0;
    logic  expect_fill = 1'b0;

    always #5 clk = ~clk;

    dcache_top u_dut (.*);

    mem_model #(
        .FILL_KEY(FILL_KEY),
        .SEED    (59024)
    ) u_mem (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (mem_req_valid_o),
        .req_we_i    (mem_req_we_o),
        .req_addr_i  (mem_req_addr_o),
        .req_wdata_i (mem_req_wdata_o),
        .req_ready_o (mem_req_ready_i),
        .resp_valid_o(mem_resp_valid_i),
        .resp_rdata_o(mem_resp_rdata_i)
    );

    function automatic logic [7:0] golden_byte(addr_t a);
        word_t pat;
        if (golden.exists(a)) begin
            return golden[a];
        end
        pat = {a[31:2], 2'b00} ^ FILL_KEY;
        return pat[a[1:0]*8 +: 8];
    endfunction

    function automatic word_t golden_word(addr_t a);
        word_t w;
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = golden_byte({a[31:2], 2'b00} + b);
        end
        return w;
    endfunction

    function automatic line_t golden_line(addr_t a);
        line_t l;
        for (int b = 0; b < LINE_W / 8; b++) begin
            l[b*8 +: 8] = golden_byte({a[31:4], 4'h0} + b);
        end
        return l;
    endfunction

    task automatic note_err(input string msg);
        $display("ERR %0t: %s", $time, msg);
        err_cnt++;
    endtask

    // one request through the CPU port until its response is seen
    task automatic access(input addr_t addr, input strb_t strb, input word_t data);
        @(negedge clk);
        req_valid_i = 1'b1;
        req_addr_i  = addr;
        req_wstrb_i = strb;
        req_wdata_i = data;
        while (!req_ready_o) begin
            @(negedge clk);
        end
        // taken on the coming rising edge
        exp_load  = (strb == '0);
        exp_rdata = golden_word(addr);
        cur_addr  = addr;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                golden[{addr[31:2], 2'b00} + b] = data[b*8 +: 8];
            end
        end
        @(negedge clk);
        req_valid_i = 1'b0;
        while (!resp_valid_o) begin
            @(negedge clk);
        end
    endtask

    // four tags over four sets keep both ways busy
    task automatic random_access();
        word_t r;
        word_t d;
        strb_t strb;
        r = $random(seed);
        d = $random(seed);
        case (r[10:8])
            3'd3:    strb = 4'b0001 << r[12:11];
            3'd4:    strb = r[11] ? 4'b1100 : 4'b0011;
            3'd5:    strb = 4'b1111;
            default: strb = 4'b0000;
        endcase
        access({20'h30000, r[1:0], 4'h0, r[3:2], r[5:4], 2'b00}, strb, d);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt == err_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_cnt - err_before);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            fill_seen <= 1'b0;
        end else begin
            if (req_valid_i && req_ready_o) begin
                pending   <= 1'b1;
                fill_seen <= 1'b0;
            end else begin
                if (resp_valid_o) begin
                    pending <= 1'b0;
                end
                if (mem_req_valid_o && mem_req_ready_i && !mem_req_we_o) begin
                    fill_seen <= 1'b1;
                end
            end
            if (mem_req_valid_o && mem_req_ready_i && mem_req_we_o) begin
                a_wb_line: assert (mem_req_wdata_o == golden_line(mem_req_addr_o))
                    else note_err($sformatf("write-back to %h carries %h, expected %h",
                        mem_req_addr_o, mem_req_wdata_o, golden_line(mem_req_addr_o)));
            end
        end
    end

    a_reset_state: assert property (@(posedge clk) !rst && $past(rst)
        |-> req_ready_o && !resp_valid_o && !mem_req_valid_o)
        else note_err($sformatf("after reset ready=%b resp_valid=%b mem_req_valid=%b",
            req_ready_o, resp_valid_o, mem_req_valid_o));

    a_load_data: assert property (@(posedge clk) disable iff (rst)
        resp_valid_o && exp_load |-> resp_rdata_o == exp_rdata)
        else note_err($sformatf("load from %h returned %h, expected %h",
            cur_addr, resp_rdata_o, exp_rdata));

    a_resp_owed: assert property (@(posedge clk) disable iff (rst) resp_valid_o |-> pending)
        else note_err("response came without an accepted request");

    a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
        req_ready_o |-> !pending)
        else note_err("cache was ready while a request was still outstanding");

    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        req_valid_i && req_ready_o && expect_hit |=> resp_valid_o && !mem_req_valid_o)
        else note_err("hit was not answered in the cycle after acceptance");

    a_single_fill: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_o && mem_req_ready_i && !mem_req_we_o |-> !fill_seen)
        else note_err("more than one memory read for a single request");

    a_fill_issued: assert property (@(posedge clk) disable iff (rst)
        resp_valid_o && expect_fill |-> fill_seen)
        else note_err("miss was answered without a memory read");

    a_fill_addr: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_o && mem_req_ready_i && !mem_req_we_o
        |-> mem_req_addr_o == {cur_addr[31:4], 4'h0})
        else note_err($sformatf("refill address %h for request %h", mem_req_addr_o, cur_addr));

    a_wb_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_o && mem_req_we_o |-> mem_req_addr_o[3:0] == 4'h0)
        else note_err($sformatf("write-back address %h is not line aligned", mem_req_addr_o));

    a_mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_we_o)
            && $stable(mem_req_addr_o) && $stable(mem_req_wdata_o))
        else note_err("memory request changed while stalled");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int    err_before;
        word_t d;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        err_before = err_cnt;
        repeat (3) @(negedge clk);
        finish_test("reset state", err_before);

        err_before  = err_cnt;
        expect_fill = 1'b1;
        access(32'h1000_0044, '0, '0);
        expect_fill = 1'b0;
        finish_test("read miss", err_before);

        err_before = err_cnt;
        expect_hit = 1'b1;
        access(32'h1000_0044, '0, '0);
        access(32'h1000_0048, '0, '0);
        access(32'h1000_0040, '0, '0);
        expect_hit = 1'b0;
        finish_test("read hit", err_before);

        err_before = err_cnt;
        for (int w = 0; w < 4; w++) begin
            for (int s = 0; s < 7; s++) begin
                d = $random(seed);
                access(32'h1000_0040 + w * 4, merge_strb[s], d);
                access(32'h1000_0040 + w * 4, '0, '0);
            end
        end
        // stores that miss use one fresh set per word offset
        for (int w = 0; w < 4; w++) begin
            d = $random(seed);
            access(32'h1100_0000 + w * 32'h14, 4'b0001 << w, d);
            access(32'h1100_0000 + w * 32'h14, '0, '0);
        end
        finish_test("store merge", err_before);

        err_before = err_cnt;
        for (int t = 0; t < 4; t++) begin
            for (int w = 0; w < 4; w++) begin
                d = $random(seed);
                access(32'h2000_0050 + t * 32'h400 + w * 4, 4'b1111, d);
            end
        end
        for (int t = 0; t < 4; t++) begin
            for (int w = 0; w < 4; w++) begin
                access(32'h2000_0050 + t * 32'h400 + w * 4, '0, '0);
            end
        end
        finish_test("eviction", err_before);

        err_before = err_cnt;
        repeat (300) random_access();
        finish_test("random mix", err_before);

        repeat (5) @(negedge clk);
        $display("tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# builds the dcache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dcache -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_dcache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// File: source/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter  int NSET  = 64,
    localparam int IDX_W = $clog2(NSET),
    localparam int TAG_W = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFFSET_W
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid_i,
    input  dcache_pkg::addr_t            req_addr_i,
    input  dcache_pkg::strb_t            req_wstrb_i,
    input  dcache_pkg::word_t            req_wdata_i,
    output logic                         req_ready_o,
    output logic                         resp_valid_o,
    output dcache_pkg::word_t            resp_rdata_o,
    output logic                         mem_req_valid_o,
    output logic                         mem_req_we_o,
    output dcache_pkg::addr_t            mem_req_addr_o,
    output dcache_pkg::line_t            mem_req_wdata_o,
    input  logic                         mem_req_ready_i,
    input  logic                         mem_resp_valid_i,
    input  dcache_pkg::line_t            mem_resp_rdata_i,
    input  logic [1:0]                   way_valid_i,
    input  logic [1:0]                   way_dirty_i,
    input  logic [1:0][TAG_W-1:0]        way_tag_i,
    input  dcache_pkg::line_t [1:0]      way_line_i,
    output logic [IDX_W-1:0]             rd_index_o,
    output logic [1:0]                   way_we_o,
    output logic [IDX_W-1:0]             wr_index_o,
    output logic [TAG_W-1:0]             wr_tag_o,
    output logic                         wr_dirty_o,
    output dcache_pkg::line_t            wr_line_o
);
    import dcache_pkg::*;

    localparam int WSEL_W = $clog2(WORDS_PER_LINE);

    cache_state_e     state, next_state;
    addr_t            req_addr_q;
    strb_t            req_wstrb_q;
    word_t            req_wdata_q;
    logic [15:0]      lfsr_q;
    logic             victim_q;
    logic [1:0]       hit;
    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic             is_store;
    line_t            merge_line_in;
    line_t            merged_line;
    word_t            sel_word;

    assign req_idx  = req_addr_q[OFFSET_W +: IDX_W];
    assign req_tag  = req_addr_q[ADDR_W-1 -: TAG_W];
    assign is_store = |req_wstrb_q;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = way_valid_i[w] && (way_tag_i[w] == req_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready_o && req_valid_i) begin
            req_addr_q  <= req_addr_i;
            req_wstrb_q <= req_wstrb_i;
            req_wdata_q <= req_wdata_i;
        end
        // victim is fixed once the lookup misses
        if (state == LOOKUP) begin
            victim_q <= lfsr_q[0];
        end
    end

    // free running LFSR on x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= 16'h0001;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (req_valid_i) next_state = LOOKUP;
            end
            LOOKUP: begin
                if (|hit) begin
                    next_state = IDLE;
                end else if (way_valid_i[lfsr_q[0]] && way_dirty_i[lfsr_q[0]]) begin
                    next_state = WB_REQ;
                end else begin
                    next_state = FILL_REQ;
                end
            end
            WB_REQ: begin
                if (mem_req_ready_i) next_state = WB_WAIT;
            end
            WB_WAIT: begin
                if (mem_resp_valid_i) next_state = FILL_REQ;
            end
            FILL_REQ: begin
                if (mem_req_ready_i) next_state = FILL_WAIT;
            end
            FILL_WAIT: begin
                if (mem_resp_valid_i) next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_comb begin
        resp_valid_o    = 1'b0;
        way_we_o        = 2'b00;
        mem_req_valid_o = 1'b0;
        mem_req_we_o    = 1'b0;
        mem_req_addr_o  = {req_tag, req_idx, {OFFSET_W{1'b0}}};
        case (state)
            LOOKUP: begin
                if (|hit) begin
                    resp_valid_o = 1'b1;
                    way_we_o     = hit & {2{is_store}};
                end
            end
            WB_REQ: begin
                mem_req_valid_o = 1'b1;
                mem_req_we_o    = 1'b1;
                mem_req_addr_o  = {way_tag_i[victim_q], req_idx, {OFFSET_W{1'b0}}};
            end
            FILL_REQ: begin
                mem_req_valid_o = 1'b1;
            end
            FILL_WAIT: begin
                if (mem_resp_valid_i) begin
                    resp_valid_o       = 1'b1;
                    way_we_o[victim_q] = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    assign req_ready_o     = (state == IDLE);
    // the set is reread while the miss is serviced so the victim stays on the bus
    assign rd_index_o      = (state == IDLE) ? req_addr_i[OFFSET_W +: IDX_W] : req_idx;
    assign mem_req_wdata_o = way_line_i[victim_q];
    assign merge_line_in   = (state == FILL_WAIT) ? mem_resp_rdata_i : way_line_i[hit[1]];
    assign wr_index_o      = req_idx;
    assign wr_tag_o        = req_tag;
    assign wr_dirty_o      = is_store;
    assign wr_line_o       = merged_line;
    assign resp_rdata_o    = sel_word;

    dcache_line_merge u_merge (
        .line_i  (merge_line_in),
        .offset_i(req_addr_q[OFFSET_W-1 -: WSEL_W]),
        .wstrb_i (req_wstrb_q),
        .wdata_i (req_wdata_q),
        .line_o  (merged_line),
        .word_o  (sel_word)
    );

    a_mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_we_o)
            && $stable(mem_req_addr_o) && $stable(mem_req_wdata_o));

    a_no_resp_in_idle: assert property (@(posedge clk) disable iff (rst)
        resp_valid_o |=> state == IDLE && !resp_valid_o);

    a_single_hit: assert property (@(posedge clk) disable iff (rst)
        state == LOOKUP |-> $onehot0(hit));

endmodule

// File: source/dcache_line_merge.sv
`timescale 1ns/1ps

module dcache_line_merge (
    input  dcache_pkg::line_t                                  line_i,
    input  logic [$clog2(dcache_pkg::WORDS_PER_LINE)-1:0]      offset_i,
    input  dcache_pkg::strb_t                                  wstrb_i,
    input  dcache_pkg::word_t                                  wdata_i,
    output dcache_pkg::line_t                                  line_o,
    output dcache_pkg::word_t                                  word_o
);
    import dcache_pkg::*;

    // load word comes from the line before any store bytes land
    assign word_o = line_i[offset_i*WORD_W +: WORD_W];

    always_comb begin
        line_o = line_i;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (wstrb_i[b]) begin
                line_o[offset_i*WORD_W + b*8 +: 8] = wdata_i[b*8 +: 8];
            end
        end
    end

endmodule

// File: source/dcache_pkg.sv
package dcache_pkg;

    // address and data widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int LINE_W = 128;

    // line geometry
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;
    localparam int OFFSET_W = $clog2(LINE_W / 8);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    // all zeros marks a load
    typedef logic [WORD_W/8-1:0] strb_t;
    typedef logic [LINE_W-1:0] line_t;

    // one request in flight, miss states follow LOOKUP
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_WAIT,
        FILL_REQ,
        FILL_WAIT
    } cache_state_e;

endpackage

// File: source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int NSET = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid_i,
    input  dcache_pkg::addr_t  req_addr_i,
    input  dcache_pkg::strb_t  req_wstrb_i,
    input  dcache_pkg::word_t  req_wdata_i,
    output logic               req_ready_o,
    output logic               resp_valid_o,
    output dcache_pkg::word_t  resp_rdata_o,
    output logic               mem_req_valid_o,
    output logic               mem_req_we_o,
    output dcache_pkg::addr_t  mem_req_addr_o,
    output dcache_pkg::line_t  mem_req_wdata_o,
    input  logic               mem_req_ready_i,
    input  logic               mem_resp_valid_i,
    input  dcache_pkg::line_t  mem_resp_rdata_i
);
    import dcache_pkg::*;

    localparam int IDX_W = $clog2(NSET);
    localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;

    logic [IDX_W-1:0]      rd_index;
    logic [IDX_W-1:0]      wr_index;
    logic [1:0]            way_we;
    logic [1:0]            way_valid;
    logic [1:0]            way_dirty;
    logic [1:0][TAG_W-1:0] way_tag;
    line_t [1:0]           way_line;
    logic [TAG_W-1:0]      wr_tag;
    logic                  wr_dirty;
    line_t                 wr_line;

    dcache_ctrl #(
        .NSET(NSET)
    ) u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_addr_i      (req_addr_i),
        .req_wstrb_i     (req_wstrb_i),
        .req_wdata_i     (req_wdata_i),
        .req_ready_o     (req_ready_o),
        .resp_valid_o    (resp_valid_o),
        .resp_rdata_o    (resp_rdata_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_we_o    (mem_req_we_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_wdata_o (mem_req_wdata_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_resp_valid_i(mem_resp_valid_i),
        .mem_resp_rdata_i(mem_resp_rdata_i),
        .way_valid_i     (way_valid),
        .way_dirty_i     (way_dirty),
        .way_tag_i       (way_tag),
        .way_line_i      (way_line),
        .rd_index_o      (rd_index),
        .way_we_o        (way_we),
        .wr_index_o      (wr_index),
        .wr_tag_o        (wr_tag),
        .wr_dirty_o      (wr_dirty),
        .wr_line_o       (wr_line)
    );

    // both ways share the read index and the write payload
    for (genvar w = 0; w < 2; w++) begin : g_way
        dcache_way_ram #(
            .NSET(NSET)
        ) u_way (
            .clk       (clk),
            .rst       (rst),
            .rd_index_i(rd_index),
            .we_i      (way_we[w]),
            .wr_index_i(wr_index),
            .wr_tag_i  (wr_tag),
            .wr_dirty_i(wr_dirty),
            .wr_line_i (wr_line),
            .rd_valid_o(way_valid[w]),
            .rd_dirty_o(way_dirty[w]),
            .rd_tag_o  (way_tag[w]),
            .rd_line_o (way_line[w])
        );
    end

endmodule

// File: source/dcache_way_ram.sv
`timescale 1ns/1ps

module dcache_way_ram #(
    parameter  int NSET  = 64,
    localparam int IDX_W = $clog2(NSET),
    localparam int TAG_W = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFFSET_W
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [IDX_W-1:0]   rd_index_i,
    input  logic               we_i,
    input  logic [IDX_W-1:0]   wr_index_i,
    input  logic [TAG_W-1:0]   wr_tag_i,
    input  logic               wr_dirty_i,
    input  dcache_pkg::line_t  wr_line_i,
    output logic               rd_valid_o,
    output logic               rd_dirty_o,
    output logic [TAG_W-1:0]   rd_tag_o,
    output dcache_pkg::line_t  rd_line_o
);
    import dcache_pkg::*;

    logic [TAG_W-1:0] tag_mem [NSET];
    logic             dirty_mem [NSET];
    line_t            line_mem [NSET];
    logic [NSET-1:0]  valid_q;

    // tag, dirty and data arrays
    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[wr_index_i]   <= wr_tag_i;
            dirty_mem[wr_index_i] <= wr_dirty_i;
            line_mem[wr_index_i]  <= wr_line_i;
        end
        rd_tag_o   <= tag_mem[rd_index_i];
        rd_dirty_o <= dirty_mem[rd_index_i];
        rd_line_o  <= line_mem[rd_index_i];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            if (we_i) begin
                valid_q[wr_index_i] <= 1'b1;
            end
            rd_valid_o <= valid_q[rd_index_i];
        end
    end

endmodule

// File: vlog.f
source/dcache_pkg.sv
source/dcache_line_merge.sv
source/dcache_way_ram.sv
source/dcache_ctrl.sv
source/dcache_top.sv
bench/mem_model.sv
bench/tb_dcache.sv
